/* hdl/fpu_pkg.sv */
package fpu_pkg;

  // ====================================================================
  // opcodes
  // ====================================================================

  // op[3:2] picks the unit, op[1:0] the sub-function
  typedef enum logic [3:0] {
    cmp_eq     = 4'h0,
    cmp_lt     = 4'h1,
    cmp_le     = 4'h2,
    cmp_un     = 4'h3,
    log_and    = 4'h4,
    log_or     = 4'h5,
    log_xor    = 4'h6,
    log_andn   = 4'h7,
    perm_swap  = 4'h8,
    perm_dupl  = 4'h9,
    perm_duph  = 4'ha,
    perm_passb = 4'hb
  } fpu_op_t;

  typedef enum logic [1:0] {
    unit_cmp   = 2'd0,
    unit_logic = 2'd1,
    unit_perm  = 2'd2
  } unit_sel_t;

  // ====================================================================
  // data widths
  // ====================================================================

  typedef logic [63:0] fp_data_t;  // compare looks at [31:0] only
  typedef logic [3:0]  fp_tag_t;   // reorder tag
  typedef logic [31:0] fp_csr_t;

  // ====================================================================
  // control register fields
  // ====================================================================

  localparam int csr_inv_en = 11;  // invalid exception enable

endpackage

/* hdl/fpu_decode.sv */
`timescale 1ns/100ps

module fpu_decode import fpu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      iss_valid,
  input  fpu_op_t   iss_op,
  input  fp_tag_t   iss_tag,
  input  fp_data_t  iss_a,
  input  fp_data_t  iss_b,
  input  logic      fwd_a,
  input  logic      fwd_b,
  output logic      dec_valid,
  output unit_sel_t dec_unit,
  output logic [1:0] dec_func,
  output fp_tag_t   dec_tag,
  output fp_data_t  dec_a,
  output fp_data_t  dec_b,
  output logic      dec_fwd_a,
  output logic      dec_fwd_b
);

  unit_sel_t unit_nxt;

  // unit select from the upper opcode bits
  always_comb begin
    case (iss_op[3:2])
      2'b00:   unit_nxt = unit_cmp;
      2'b01:   unit_nxt = unit_logic;
      default: unit_nxt = unit_perm;  // 4'hc..f unused
    endcase
  end

  // ====================================================================
  // issue register
  // ====================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= iss_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (iss_valid) begin
      dec_unit  <= unit_nxt;
      dec_func  <= iss_op[1:0];  // sub-function
      dec_tag   <= iss_tag;
      dec_a     <= iss_a;
      dec_b     <= iss_b;
      dec_fwd_a <= fwd_a;
      dec_fwd_b <= fwd_b;
    end
  end

endmodule

/* hdl/fpu_execute.sv */
`timescale 1ns/100ps

module fpu_execute import fpu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       dec_valid,
  input  unit_sel_t  dec_unit,
  input  logic [1:0] dec_func,
  input  fp_tag_t    dec_tag,
  input  fp_data_t   dec_a,
  input  fp_data_t   dec_b,
  input  logic       dec_fwd_a,
  input  logic       dec_fwd_b,
  output logic       ex_valid,
  output fp_tag_t    ex_tag,
  output fp_data_t   ex_data,
  output logic       ex_inv
);

  fp_data_t    op_a;
  fp_data_t    op_b;
  logic [31:0] sa;
  logic [31:0] sb;
  logic        nan_a;
  logic        nan_b;
  logic        any_nan;
  logic        any_snan;
  logic        zero_both;
  logic        eq_raw;
  logic        lt_raw;
  logic        cmp_bit;
  logic        cmp_inv;
  fp_data_t    logic_res;
  fp_data_t    perm_res;
  fp_data_t    res;

  assign op_a = dec_fwd_a ? ex_data : dec_a;  // bypass from previous result
  assign op_b = dec_fwd_b ? ex_data : dec_b;

  // ====================================================================
  // single precision compare
  // ====================================================================

  assign sa = op_a[31:0];
  assign sb = op_b[31:0];

  assign nan_a    = (&sa[30:23]) & (|sa[22:0]);
  assign nan_b    = (&sb[30:23]) & (|sb[22:0]);
  assign any_nan  = nan_a | nan_b;
  assign any_snan = (nan_a & ~sa[22]) | (nan_b & ~sb[22]);  // quiet bit clear

  assign zero_both = ~|{sa[30:0], sb[30:0]};  // +0 == -0
  assign eq_raw    = (sa == sb) | zero_both;

  always_comb begin
    if (zero_both)
      lt_raw = 1'b0;
    else if (sa[31] != sb[31])
      lt_raw = sa[31];
    else if (sa[31])
      lt_raw = sa[30:0] > sb[30:0];  // both negative
    else
      lt_raw = sa[30:0] < sb[30:0];
  end

  always_comb begin
    case (dec_func)
      2'd0: begin
        cmp_bit = eq_raw & ~any_nan;
        cmp_inv = any_snan;
      end
      2'd1: begin
        cmp_bit = lt_raw & ~any_nan;
        cmp_inv = any_nan;
      end
      2'd2: begin
        cmp_bit = (lt_raw | eq_raw) & ~any_nan;
        cmp_inv = any_nan;
      end
      default: begin
        cmp_bit = any_nan;  // unordered
        cmp_inv = any_snan;
      end
    endcase
  end

  // ====================================================================
  // logic, permute and result select
  // ====================================================================

  always_comb begin
    case (dec_func)
      2'd0:    logic_res = op_a & op_b;
      2'd1:    logic_res = op_a | op_b;
      2'd2:    logic_res = op_a ^ op_b;
      default: logic_res = op_a & ~op_b;
    endcase
    case (dec_func)
      2'd0:    perm_res = {op_a[31:0], op_a[63:32]};
      2'd1:    perm_res = {op_a[31:0], op_a[31:0]};
      2'd2:    perm_res = {op_a[63:32], op_a[63:32]};
      default: perm_res = op_b;
    endcase
    case (dec_unit)
      unit_cmp:   res = {63'd0, cmp_bit};
      unit_logic: res = logic_res;
      default:    res = perm_res;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ex_tag  <= dec_tag;
      ex_data <= res;
      ex_inv  <= (dec_unit == unit_cmp) & cmp_inv;
    end
  end

endmodule

/* hdl/fpu_result.sv */
`timescale 1ns/100ps

module fpu_result import fpu_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  fp_csr_t  fpcsr,
  input  logic     ex_valid,
  input  fp_tag_t  ex_tag,
  input  fp_data_t ex_data,
  input  logic     ex_inv,
  input  logic     out_credit,
  output logic     out_valid,
  output fp_tag_t  out_tag,
  output fp_data_t out_data,
  output logic     out_exc,
  output logic     sticky_inv,
  output logic     iss_credit
);

  localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
  localparam int CRED_W = 8;

  fp_tag_t           q_tag  [QUEUE_DEPTH];
  fp_data_t          q_data [QUEUE_DEPTH];
  logic              q_exc  [QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  q_cnt;
  logic [CRED_W-1:0] out_cred;
  logic              exc_in;
  logic              pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(QUEUE_DEPTH - 1))
      return '0;
    return p + 1'b1;
  endfunction

  assign exc_in = ex_inv & fpcsr[csr_inv_en];  // masked retire code

  always_ff @(posedge clk) begin
    if (rst)
      sticky_inv <= 1'b0;
    else if (ex_valid && ex_inv)
      sticky_inv <= 1'b1;  // set regardless of the mask
  end

  // ====================================================================
  // result queue and output credits
  // ====================================================================

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      q_tag[wr_ptr]  <= ex_tag;
      q_data[wr_ptr] <= ex_data;
      q_exc[wr_ptr]  <= exc_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      q_cnt    <= '0;
      out_cred <= '0;
    end else begin
      if (ex_valid)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({ex_valid, pop})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
      out_cred <= out_cred + CRED_W'(out_credit) - CRED_W'(pop);
    end
  end

  assign pop        = (q_cnt != '0) && (out_cred != '0);
  assign out_valid  = pop;
  assign out_tag    = q_tag[rd_ptr];
  assign out_data   = q_data[rd_ptr];
  assign out_exc    = q_exc[rd_ptr];
  assign iss_credit = pop;  // freed slot goes back to the scheduler

endmodule

/* hdl/fpu_cluster.sv */
`timescale 1ns/100ps

module fpu_cluster import fpu_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  fp_csr_t  fpcsr,
  input  logic     iss_valid,
  input  fpu_op_t  iss_op,
  input  fp_tag_t  iss_tag,
  input  fp_data_t iss_a,
  input  fp_data_t iss_b,
  input  logic     fwd_a,
  input  logic     fwd_b,
  output logic     iss_credit,
  output logic     out_valid,
  output fp_tag_t  out_tag,
  output fp_data_t out_data,
  output logic     out_exc,
  input  logic     out_credit,
  output logic     sticky_inv
);

  logic       dec_valid;
  unit_sel_t  dec_unit;
  logic [1:0] dec_func;
  fp_tag_t    dec_tag;
  fp_data_t   dec_a;
  fp_data_t   dec_b;
  logic       dec_fwd_a;
  logic       dec_fwd_b;
  logic       ex_valid;
  fp_tag_t    ex_tag;
  fp_data_t   ex_data;
  logic       ex_inv;

  // ====================================================================
  // decode -> execute -> result
  // ====================================================================

  fpu_decode fpu_decode_inst (.*);

  fpu_execute fpu_execute_inst (.*);

  fpu_result #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) fpu_result_inst (
    .*
  );

endmodule

/* verif/fpu_cluster_tb.sv */
`timescale 1ns/100ps

module fpu_cluster_tb import fpu_pkg::*; ();

  localparam int QUEUE_DEPTH = 4;
  localparam int NUM_OPS     = 400;
  localparam int MAX_CYCLES  = 20 * NUM_OPS + 200;

  logic     clk = 1'b0;
  logic     rst;
  fp_csr_t  fpcsr;
  logic     iss_valid;
  fpu_op_t  iss_op;
  fp_tag_t  iss_tag;
  fp_data_t iss_a;
  fp_data_t iss_b;
  logic     fwd_a;
  logic     fwd_b;
  logic     iss_credit;
  logic     out_valid;
  fp_tag_t  out_tag;
  fp_data_t out_data;
  logic     out_exc;
  logic     out_credit;
  logic     sticky_inv;

  integer   seed = 32'h3d371343;
  fp_data_t exp_data_q[$];
  fp_tag_t  exp_tag_q[$];
  logic     exp_exc_q[$];
  logic     exp_inv_q[$];
  int       iss_cred;
  int       out_grants;
  int       issued;
  int       beats;
  int       returns;
  int       cycles;
  int       data_errs;
  int       tag_errs;
  int       bit_errs;
  int       proto_errs;
  logic     prev_issued;
  logic     inv_seen;
  logic     inv_out;
  fp_data_t prev_res;
  fp_tag_t  next_tag;

  fpu_cluster #(.QUEUE_DEPTH(QUEUE_DEPTH)) fpu_cluster_inst (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: results stopped arriving after %0d cycles", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ====================================================================
  // reference model
  // ====================================================================

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  // sign-magnitude to a signed key where -0 and +0 both map to 0
  function automatic logic signed [32:0] order_key(input logic [31:0] x);
    logic signed [32:0] mag;
    mag = {2'b00, x[30:0]};
    return x[31] ? -mag : mag;
  endfunction

  // returns {invalid, result}
  function automatic logic [64:0] model_op(input fpu_op_t op, input fp_data_t a,
                                           input fp_data_t b);
    logic               unord;
    logic               sig;
    logic signed [32:0] ka;
    logic signed [32:0] kb;
    unord = is_nan(a[31:0]) || is_nan(b[31:0]);
    sig   = (is_nan(a[31:0]) && !a[22]) || (is_nan(b[31:0]) && !b[22]);
    ka    = order_key(a[31:0]);
    kb    = order_key(b[31:0]);
    case (op)
      cmp_eq:    return {sig, 63'd0, !unord && (ka == kb)};
      cmp_lt:    return {unord, 63'd0, !unord && (ka < kb)};
      cmp_le:    return {unord, 63'd0, !unord && (ka <= kb)};
      cmp_un:    return {sig, 63'd0, unord};
      log_and:   return {1'b0, a & b};
      log_or:    return {1'b0, a | b};
      log_xor:   return {1'b0, a ^ b};
      log_andn:  return {1'b0, a & ~b};
      perm_swap: return {1'b0, a[31:0], a[63:32]};
      perm_dupl: return {1'b0, a[31:0], a[31:0]};
      perm_duph: return {1'b0, a[63:32], a[63:32]};
      default:   return {1'b0, b};
    endcase
  endfunction

  // single precision operand biased toward NaN, infinity and zero
  function automatic logic [31:0] rand_sp();
    logic [31:0] r;
    int          sel;
    r   = $random(seed);
    sel = {$random(seed)} % 8;
    case (sel)
      0:       return {r[31], 8'hff, 1'b1, r[21:0]};         // quiet NaN
      1:       return {r[31], 8'hff, 1'b0, r[21:1], 1'b1};   // signaling NaN
      2:       return {r[31], 8'hff, 23'd0};                 // infinity
      3:       return {r[31], 31'd0};
      default: return r;
    endcase
  endfunction

  // ====================================================================
  // checks
  // ====================================================================

  task automatic check_data(input fp_data_t got, input fp_data_t exp, input fp_tag_t tag);
    if (got !== exp) begin
      data_errs++;
      $display("Error at %0t: data for tag %0h is %h, expected %h", $time, tag, got, exp);
    end
  endtask

  task automatic check_tag(input fp_tag_t got, input fp_tag_t exp);
    if (got !== exp) begin
      tag_errs++;
      $display("Error at %0t: out_tag is %0h, expected %0h", $time, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      bit_errs++;
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_idle();
    @(negedge clk);
    if (out_valid !== 1'b0 || iss_credit !== 1'b0 || sticky_inv !== 1'b0) begin
      proto_errs++;
      $display("out_valid, iss_credit or sticky_inv not low around reset at %0t", $time);
    end
  endtask

  // checks what the last edge produced and drives the next inputs
  task automatic step(input bit allow_issue);
    fp_tag_t    tag;
    fp_data_t   a;
    fp_data_t   b;
    logic [64:0] m;
    @(negedge clk);
    if (iss_credit) begin
      returns++;
      iss_cred++;
    end
    if (iss_cred > QUEUE_DEPTH) begin
      proto_errs++;
      $display("more issue credits returned than were spent at %0t", $time);
    end
    if (out_valid) begin
      beats++;
      if (out_grants == 0) begin
        proto_errs++;
        $display("out_valid without a granted output credit at %0t", $time);
      end else begin
        out_grants--;
      end
      if (exp_data_q.size() == 0) begin
        proto_errs++;
        $display("result delivered with no op outstanding at %0t", $time);
      end else begin
        tag = exp_tag_q.pop_front();
        check_tag(out_tag, tag);
        check_data(out_data, exp_data_q.pop_front(), tag);
        check_bit(out_exc, exp_exc_q.pop_front(), "out_exc");
        if (exp_inv_q.pop_front())
          inv_out = 1'b1;
      end
    end
    if (inv_out)
      check_bit(sticky_inv, 1'b1, "sticky_inv");
    else if (!inv_seen)
      check_bit(sticky_inv, 1'b0, "sticky_inv");

    out_credit = ({$random(seed)} % 2) == 0;
    if (out_credit)
      out_grants++;
    iss_valid = 1'b0;
    fwd_a     = 1'b0;
    fwd_b     = 1'b0;
    if (allow_issue && iss_cred > 0 && ({$random(seed)} % 4) != 0) begin
      iss_op = fpu_op_t'(4'({$random(seed)} % 12));
      iss_a  = {$random(seed), rand_sp()};
      iss_b  = {$random(seed), (({$random(seed)} % 4) == 0) ? iss_a[31:0] : rand_sp()};
      fwd_a  = prev_issued && (({$random(seed)} % 4) == 0);
      fwd_b  = prev_issued && (({$random(seed)} % 4) == 0);
      a      = fwd_a ? prev_res : iss_a;
      b      = fwd_b ? prev_res : iss_b;
      m      = model_op(iss_op, a, b);
      exp_data_q.push_back(m[63:0]);
      exp_tag_q.push_back(next_tag);
      exp_exc_q.push_back(m[64] & fpcsr[csr_inv_en]);
      exp_inv_q.push_back(m[64]);
      inv_seen  = inv_seen | m[64];
      prev_res  = m[63:0];
      iss_tag   = next_tag;
      iss_valid = 1'b1;
      next_tag++;
      iss_cred--;
      issued++;
    end
    prev_issued = iss_valid;
  endtask

  task automatic drain();
    while (exp_data_q.size() != 0 || iss_cred != QUEUE_DEPTH)
      step(1'b0);
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================

  initial begin
    rst         = 1'b1;
    fpcsr       = '0;
    iss_valid   = 1'b0;
    iss_op      = cmp_eq;
    iss_tag     = '0;
    iss_a       = '0;
    iss_b       = '0;
    fwd_a       = 1'b0;
    fwd_b       = 1'b0;
    out_credit  = 1'b0;
    iss_cred    = QUEUE_DEPTH;
    out_grants  = 0;
    issued      = 0;
    beats       = 0;
    returns     = 0;
    cycles      = 0;
    data_errs   = 0;
    tag_errs    = 0;
    bit_errs    = 0;
    proto_errs  = 0;
    prev_issued = 1'b0;
    inv_seen    = 1'b0;
    inv_out     = 1'b0;
    prev_res    = '0;
    next_tag    = '0;

    repeat (5) check_idle();
    rst = 1'b0;
    check_idle();

    fpcsr = fp_csr_t'($random(seed)) | (fp_csr_t'(1) << csr_inv_en);   // invalid enabled
    while (issued < NUM_OPS / 2)
      step(1'b1);
    drain();
    fpcsr = fp_csr_t'($random(seed)) & ~(fp_csr_t'(1) << csr_inv_en);  // invalid masked
    while (issued < NUM_OPS)
      step(1'b1);
    drain();

    if (returns != beats || iss_cred != QUEUE_DEPTH) begin
      proto_errs++;
      $display("issue credits out of balance: %0d returned, %0d results, %0d held",
               returns, beats, iss_cred);
    end
    $display("errors: data %0d, tag %0d, exc/flag %0d, protocol %0d",
             data_errs, tag_errs, bit_errs, proto_errs);
    if (data_errs + tag_errs + bit_errs + proto_errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* verilog.f */
hdl/fpu_pkg.sv
hdl/fpu_decode.sv
hdl/fpu_execute.sv
hdl/fpu_result.sv
hdl/fpu_cluster.sv
verif/fpu_cluster_tb.sv

/* Makefile */
TOP = fpu_cluster_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -o V$(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
